// File: verilog.f
source/frame_buffer_pkg.sv
source/burst_tag_fifo.sv
source/burst_addr_gen.sv
source/frame_ring.sv
source/write_beat_framer.sv
source/read_beat_framer.sv
source/frame_buffer_top.sv
tb/frame_buffer_properties.sv
tb/frame_buffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the frame buffer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module frame_buffer_tb \
    --Mdir obj_dir -o Vframe_buffer_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vframe_buffer_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
fi

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1

// File: tb/frame_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_tb import frame_buffer_pkg::*;
();

    localparam logic [31:0] SEED            = 32'h86cd_fc4d;
    localparam int          FRAMES_TO_WRITE = 6;
    localparam int          TOTAL_PIX       = FRAMES_TO_WRITE * FRAME_DWORDS;
    localparam int          TIMEOUT_CYCLES  = TOTAL_PIX * 4 + 1040;   // 2000
    localparam int          MEM_WORDS       = FRAME_N * FRAME_DWORDS;
    localparam int          B_DELAY         = 3;

    logic        clk;
    logic        rst_n;
    logic        disp_suspend_i = 1'b0;
    logic        rd_new_frame_o;
    logic [31:0] s_pix_data_i   = '0;
    logic        s_pix_valid_i  = 1'b0;
    logic        s_pix_ready_o;
    pix_beat_t   m_pix_o;
    logic        m_pix_valid_o;
    logic        m_pix_ready_i  = 1'b0;
    addr_req_t   m_ar_o;
    logic        m_ar_valid_o;
    logic        m_ar_ready_i   = 1'b0;
    logic [1:0]  m_arburst_o;
    logic [2:0]  m_arsize_o;
    logic [31:0] m_r_data_i     = '0;
    logic        m_r_last_i     = 1'b0;
    logic        m_r_valid_i    = 1'b0;
    logic        m_r_ready_o;
    addr_req_t   m_aw_o;
    logic        m_aw_valid_o;
    logic        m_aw_ready_i   = 1'b0;
    logic [1:0]  m_awburst_o;
    logic [2:0]  m_awsize_o;
    wr_beat_t    m_w_o;
    logic        m_w_valid_o;
    logic        m_w_ready_i    = 1'b0;
    logic [3:0]  m_w_strb_o;
    logic        m_b_valid_i    = 1'b0;
    logic        m_b_ready_o;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] aw_addr_q [$];
    logic [7:0]  aw_len_q [$];
    logic [31:0] ar_addr_q [$];
    logic [7:0]  ar_len_q [$];
    int          b_due_q [$];
    logic [31:0] rng = SEED;
    int          cycle = 0;
    int          w_cnt = 0;
    int          r_cnt = 0;
    int          pix_sent = 0;
    int          mem_errors = 0;
    int          data_errors = 0;
    int          out_idx = 0;
    logic [7:0]  top_q = '0;
    logic        last_frame_seen = 1'b0;

    frame_buffer_top u_dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr - BUF_BASE_ADDR) >> 2);
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

    // memory slave, pixel source and pixel sink
    always @(posedge clk)
    begin
        int  idx;
        logic r_hs;
        if (!rst_n)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] = {8'hF0 | 8'(i / FRAME_DWORDS), 8'h00, 16'(i % FRAME_DWORDS)};
        end
        else
        begin
            rng = xorshift32(rng);
            if (m_aw_valid_o && m_aw_ready_i)
            begin
                aw_addr_q.push_back(m_aw_o.addr);
                aw_len_q.push_back(m_aw_o.len);
            end
            if (m_w_valid_o && m_w_ready_i)
            begin
                idx = word_index(aw_addr_q[0]) + w_cnt;
                if (idx >= 0 && idx < MEM_WORDS)
                    mem[idx] = m_w_o.data;
                else
                begin
                    mem_errors++;
                    $display("write beat at %0t falls outside the frame store", $time);
                end
                if (w_cnt == int'(aw_len_q[0]))
                begin
                    void'(aw_addr_q.pop_front());
                    void'(aw_len_q.pop_front());
                    w_cnt = 0;
                    b_due_q.push_back(cycle + B_DELAY);
                end
                else
                    w_cnt++;
            end
            m_aw_ready_i <= (rng[1:0] != 2'b00);
            m_w_ready_i  <= (aw_addr_q.size() != 0) && (rng[3:2] != 2'b00);
            if (b_due_q.size() != 0 && b_due_q[0] <= cycle)
            begin
                void'(b_due_q.pop_front());
                m_b_valid_i <= 1'b1;       // B ready is tied high
            end
            else
                m_b_valid_i <= 1'b0;

            if (m_ar_valid_o && m_ar_ready_i)
            begin
                ar_addr_q.push_back(m_ar_o.addr);
                ar_len_q.push_back(m_ar_o.len);
            end
            r_hs = m_r_valid_i && m_r_ready_o;
            if (r_hs)
            begin
                if (r_cnt == int'(ar_len_q[0]))
                begin
                    void'(ar_addr_q.pop_front());
                    void'(ar_len_q.pop_front());
                    r_cnt = 0;
                end
                else
                    r_cnt++;
            end
            if (!m_r_valid_i || r_hs)
            begin
                if (ar_addr_q.size() != 0 && rng[5:4] != 2'b00)
                begin
                    idx = word_index(ar_addr_q[0]) + r_cnt;
                    if (idx < 0 || idx >= MEM_WORDS)
                    begin
                        mem_errors++;
                        $display("read beat at %0t falls outside the frame store", $time);
                        idx = 0;
                    end
                    m_r_data_i  <= mem[idx];
                    m_r_last_i  <= (r_cnt == int'(ar_len_q[0]));
                    m_r_valid_i <= 1'b1;
                end
                else
                    m_r_valid_i <= 1'b0;
            end
            m_ar_ready_i <= (rng[7:6] != 2'b00);

            // pixel source, frame number on top and word index below
            if (s_pix_valid_i && s_pix_ready_o)
                pix_sent++;
            if (!s_pix_valid_i || s_pix_ready_o)
            begin
                if (pix_sent < TOTAL_PIX && rng[9:8] != 2'b00)
                begin
                    s_pix_valid_i <= 1'b1;
                    s_pix_data_i  <= {8'(pix_sent / FRAME_DWORDS), 8'h00,
                                      16'(pix_sent % FRAME_DWORDS)};
                end
                else
                    s_pix_valid_i <= 1'b0;
            end
            m_pix_ready_i  <= (rng[11:10] != 2'b00);
            disp_suspend_i <= (cycle >= 500 && cycle < 650);
        end
    end

    // output pixel index and frame tag
    always @(posedge clk)
    begin
        if (rst_n && m_pix_valid_o && m_pix_ready_i)
        begin
            if (int'(m_pix_o.data[15:0]) != out_idx)
            begin
                data_errors++;
                $display("[ERROR] %0t m_pix_o.data[15:0] expected %0d actual %0d",
                         $time, out_idx, m_pix_o.data[15:0]);
            end
            if (out_idx != 0 && m_pix_o.data[31:24] != top_q)
            begin
                data_errors++;
                $display("[ERROR] %0t m_pix_o.data[31:24] expected %0h actual %0h",
                         $time, top_q, m_pix_o.data[31:24]);
            end
            if (m_pix_o.last != (out_idx == FRAME_DWORDS - 1))
            begin
                data_errors++;
                $display("[ERROR] %0t m_pix_o.last expected %0b actual %0b",
                         $time, (out_idx == FRAME_DWORDS - 1), m_pix_o.last);
            end
            if (out_idx == 0)
                top_q <= m_pix_o.data[31:24];
            if (out_idx == FRAME_DWORDS - 1)
            begin
                out_idx <= 0;
                if (m_pix_o.data[31:24] == 8'(FRAMES_TO_WRITE - 1))
                    last_frame_seen <= 1'b1;
            end
            else
                out_idx <= out_idx + 1;
        end
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the last written frame never reached the pixel output");
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin
        int total;
        wait (last_frame_seen);
        repeat (10) @(posedge clk);
        total = data_errors + mem_errors + u_dut.u_props.fail_cnt;
        $display("errors: data %0d, memory %0d, assertions %0d",
                 data_errors, mem_errors, u_dut.u_props.fail_cnt);
        if (total == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/frame_buffer_properties.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_properties import frame_buffer_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input addr_req_t  m_aw_o,
    input logic       aw_hs,
    input logic [1:0] m_awburst_o,
    input logic [2:0] m_awsize_o,
    input addr_req_t  m_ar_o,
    input logic       ar_hs,
    input logic [1:0] m_arburst_o,
    input logic [2:0] m_arsize_o,
    input wr_beat_t   m_w_o,
    input logic       w_hs,
    input logic [3:0] m_w_strb_o,
    input logic       b_hs,
    input logic       m_b_ready_o,
    input logic       r_last_hs,
    input pix_beat_t  m_pix_o,
    input logic       pix_hs,
    input logic       rd_new_frame_o,
    input logic       disp_suspend_i
);

    int         fail_cnt = 0;
    logic [1:0] aw_n;           // burst number within the frame
    logic [1:0] ar_n;
    int         w_word;
    int         pix_word;
    int         aw_out;
    int         ar_out;
    frame_id_t  prev_fid;
    logic       have_prev;
    logic       new_pend;

    function automatic logic place_ok(input logic [31:0] addr, input logic [1:0] n);
        logic [31:0] ofs;
        ofs = addr - BUF_BASE_ADDR;
        return (ofs < 32'(FRAME_N) * FRAME_BYTES) && (ofs % FRAME_BYTES == 32'(n) * BURST_BYTES);
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            aw_n      <= '0;
            ar_n      <= '0;
            w_word    <= 0;
            pix_word  <= 0;
            aw_out    <= 0;
            ar_out    <= 0;
            prev_fid  <= '0;
            have_prev <= 1'b0;
            new_pend  <= 1'b0;
        end
        else
        begin
            if (aw_hs) aw_n <= (aw_n == 2'd2) ? 2'd0 : aw_n + 2'd1;
            if (ar_hs) ar_n <= (ar_n == 2'd2) ? 2'd0 : ar_n + 2'd1;
            if (w_hs)
                w_word <= (w_word == FRAME_DWORDS - 1) ? 0 : w_word + 1;
            if (pix_hs)
            begin
                pix_word  <= (pix_word == FRAME_DWORDS - 1) ? 0 : pix_word + 1;
                prev_fid  <= m_pix_o.fid;
                have_prev <= 1'b1;
                new_pend  <= 1'b0;
            end
            else if (rd_new_frame_o)
                new_pend <= 1'b1;
            aw_out <= aw_out + int'(aw_hs) - int'(b_hs);
            ar_out <= ar_out + int'(ar_hs) - int'(r_last_hs);
        end
    end

    aw_seq: assert property (@(posedge clk) disable iff (!rst_n)
        aw_hs |-> place_ok(m_aw_o.addr, aw_n) && m_aw_o.len == ((aw_n == 2'd2) ? 8'd7 : 8'd15))
        else
        begin
            fail_cnt++;
            $error("AW address or length out of sequence");
        end
    ar_seq: assert property (@(posedge clk) disable iff (!rst_n)
        ar_hs |-> place_ok(m_ar_o.addr, ar_n) && m_ar_o.len == ((ar_n == 2'd2) ? 8'd7 : 8'd15))
        else
        begin
            fail_cnt++;
            $error("AR address or length out of sequence");
        end
    // INCR bursts of 4-byte beats on both address channels
    aw_attr: assert property (@(posedge clk) disable iff (!rst_n)
        aw_hs |-> m_awburst_o == 2'b01 && m_awsize_o == 3'b010)
        else
        begin
            fail_cnt++;
            $error("AW burst type or size wrong");
        end
    ar_attr: assert property (@(posedge clk) disable iff (!rst_n)
        ar_hs |-> m_arburst_o == 2'b01 && m_arsize_o == 3'b010)
        else
        begin
            fail_cnt++;
            $error("AR burst type or size wrong");
        end
    // bursts of 16 from the frame start, tail closed by the frame end
    w_last: assert property (@(posedge clk) disable iff (!rst_n)
        w_hs |-> m_w_o.last == (w_word % int'(MAX_BURST) == int'(MAX_BURST) - 1
                                || w_word == FRAME_DWORDS - 1))
        else
        begin
            fail_cnt++;
            $error("W last misplaced");
        end
    w_strb: assert property (@(posedge clk) disable iff (!rst_n)
        w_hs |-> m_w_strb_o == 4'b1111)
        else
        begin
            fail_cnt++;
            $error("W strobe not all ones");
        end
    b_ready: assert property (@(posedge clk) disable iff (!rst_n)
        m_b_ready_o)
        else
        begin
            fail_cnt++;
            $error("B ready dropped");
        end
    pix_last: assert property (@(posedge clk) disable iff (!rst_n)
        pix_hs |-> m_pix_o.last == (pix_word == FRAME_DWORDS - 1))
        else
        begin
            fail_cnt++;
            $error("pixel last misplaced");
        end
    fid_step: assert property (@(posedge clk) disable iff (!rst_n)
        pix_hs && have_prev |-> m_pix_o.fid == prev_fid + 8'(new_pend || rd_new_frame_o))
        else
        begin
            fail_cnt++;
            $error("frame id step wrong");
        end
    no_new_in_suspend: assert property (@(posedge clk) disable iff (!rst_n)
        rd_new_frame_o |-> !$past(disp_suspend_i))
        else
        begin
            fail_cnt++;
            $error("new frame while suspended");
        end
    outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        aw_out <= int'(ADDR_OUTSTANDING) && ar_out <= int'(ADDR_OUTSTANDING))
        else
        begin
            fail_cnt++;
            $error("too many bursts outstanding");
        end

endmodule

bind frame_buffer_top frame_buffer_properties u_props
(
    .clk (clk), .rst_n (rst_n),
    .m_aw_o (m_aw_o), .aw_hs (m_aw_valid_o && m_aw_ready_i),
    .m_awburst_o (m_awburst_o), .m_awsize_o (m_awsize_o),
    .m_ar_o (m_ar_o), .ar_hs (m_ar_valid_o && m_ar_ready_i),
    .m_arburst_o (m_arburst_o), .m_arsize_o (m_arsize_o),
    .m_w_o (m_w_o), .w_hs (m_w_valid_o && m_w_ready_i),
    .m_w_strb_o (m_w_strb_o),
    .b_hs (m_b_valid_i && m_b_ready_o), .m_b_ready_o (m_b_ready_o),
    .r_last_hs (m_r_valid_i && m_r_ready_o && m_r_last_i),
    .m_pix_o (m_pix_o), .pix_hs (m_pix_valid_o && m_pix_ready_i),
    .rd_new_frame_o (rd_new_frame_o), .disp_suspend_i (disp_suspend_i)
);

`default_nettype wire

// File: source/frame_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer_top import frame_buffer_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        disp_suspend_i,
    output logic        rd_new_frame_o,
    input  logic [31:0] s_pix_data_i,
    input  logic        s_pix_valid_i,
    output logic        s_pix_ready_o,
    output pix_beat_t   m_pix_o,
    output logic        m_pix_valid_o,
    input  logic        m_pix_ready_i,
    output addr_req_t   m_ar_o,
    output logic        m_ar_valid_o,
    input  logic        m_ar_ready_i,
    output logic [1:0]  m_arburst_o,
    output logic [2:0]  m_arsize_o,
    input  logic [31:0] m_r_data_i,
    input  logic        m_r_last_i,
    input  logic        m_r_valid_i,
    output logic        m_r_ready_o,
    output addr_req_t   m_aw_o,
    output logic        m_aw_valid_o,
    input  logic        m_aw_ready_i,
    output logic [1:0]  m_awburst_o,
    output logic [2:0]  m_awsize_o,
    output wr_beat_t    m_w_o,
    output logic        m_w_valid_o,
    input  logic        m_w_ready_i,
    output logic [3:0]  m_w_strb_o,
    input  logic        m_b_valid_i,
    output logic        m_b_ready_o
);

    logic        rd_frame_done;
    logic        wr_frame_done;
    logic        rd_release;
    logic        wr_release;
    logic [31:0] rd_base;
    logic [31:0] wr_base;
    frame_id_t   rd_fid;

    assign m_arburst_o = AXI_BURST_INCR;
    assign m_arsize_o  = AXI_SIZE_4B;
    assign m_awburst_o = AXI_BURST_INCR;
    assign m_awsize_o  = AXI_SIZE_4B;
    assign m_w_strb_o  = 4'b1111;
    assign m_b_ready_o = 1'b1;       // responses always taken

    frame_ring u_ring
    (
        .clk (clk), .rst_n (rst_n),
        .wr_done_i (wr_frame_done), .rd_done_i (rd_frame_done),
        .disp_suspend_i (disp_suspend_i),
        .wr_release_o (wr_release), .rd_release_o (rd_release),
        .wr_base_o (wr_base), .rd_base_o (rd_base),
        .rd_fid_o (rd_fid), .rd_new_frame_o (rd_new_frame_o)
    );

    // a read burst completes on its R last beat
    burst_addr_gen u_rd_addr
    (
        .clk (clk), .rst_n (rst_n), .frame_base_i (rd_base),
        .req_o (m_ar_o), .req_valid_o (m_ar_valid_o), .req_ready_i (m_ar_ready_i),
        .burst_done_i (m_r_valid_i && m_r_ready_o && m_r_last_i),
        .frame_done_o (rd_frame_done), .frame_release_i (rd_release)
    );

    burst_addr_gen u_wr_addr
    (
        .clk (clk), .rst_n (rst_n), .frame_base_i (wr_base),
        .req_o (m_aw_o), .req_valid_o (m_aw_valid_o), .req_ready_i (m_aw_ready_i),
        .burst_done_i (m_b_valid_i && m_b_ready_o),
        .frame_done_o (wr_frame_done), .frame_release_i (wr_release)
    );

    write_beat_framer u_wr_framer
    (
        .clk (clk), .rst_n (rst_n),
        .pix_data_i (s_pix_data_i), .pix_valid_i (s_pix_valid_i), .pix_ready_o (s_pix_ready_o),
        .w_o (m_w_o), .w_valid_o (m_w_valid_o), .w_ready_i (m_w_ready_i)
    );

    read_beat_framer u_rd_framer
    (
        .clk (clk), .rst_n (rst_n),
        .r_data_i (m_r_data_i), .r_valid_i (m_r_valid_i), .r_ready_o (m_r_ready_o),
        .fid_i (rd_fid),
        .pix_o (m_pix_o), .pix_valid_o (m_pix_valid_o), .pix_ready_i (m_pix_ready_i)
    );

endmodule

`default_nettype wire

// File: source/read_beat_framer.sv
`timescale 1ns/1ps
`default_nettype none

module read_beat_framer import frame_buffer_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] r_data_i,
    input  logic        r_valid_i,
    output logic        r_ready_o,
    input  frame_id_t   fid_i,
    output pix_beat_t   pix_o,
    output logic        pix_valid_o,
    input  logic        pix_ready_i
);

    logic [WORD_CNT_W-1:0] frame_cnt_q;
    logic                  last_q;      // next beat closes the frame
    logic                  beat;

    assign beat = r_valid_i && pix_ready_i;

    // R goes out unbuffered, id taken as the beat passes
    assign pix_o       = '{data: r_data_i, fid: fid_i, last: last_q};
    assign pix_valid_o = r_valid_i;
    assign r_ready_o   = pix_ready_i;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame_cnt_q <= '0;
            last_q      <= 1'b0;
        end
        else if (beat)
        begin
            if (frame_cnt_q == WORD_CNT_W'(FRAME_DWORDS - 1))
                frame_cnt_q <= '0;
            else
                frame_cnt_q <= frame_cnt_q + 1'b1;
            last_q <= (frame_cnt_q == WORD_CNT_W'(FRAME_DWORDS - 2));
        end
    end

endmodule

`default_nettype wire

// File: source/write_beat_framer.sv
`timescale 1ns/1ps
`default_nettype none

module write_beat_framer import frame_buffer_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] pix_data_i,
    input  logic        pix_valid_i,
    output logic        pix_ready_o,
    output wr_beat_t    w_o,
    output logic        w_valid_o,
    input  logic        w_ready_i
);

    logic [WORD_CNT_W-1:0]  frame_cnt_q;   // word index in the frame
    logic [BURST_CNT_W-1:0] burst_cnt_q;   // word index in the burst
    logic                   frame_end;
    logic                   burst_end;
    logic                   beat;

    assign frame_end = (frame_cnt_q == WORD_CNT_W'(FRAME_DWORDS - 1));
    assign burst_end = (burst_cnt_q == BURST_CNT_W'(MAX_BURST - 1));
    assign beat      = pix_valid_i && w_ready_i;

    // straight through to W
    assign w_o         = '{data: pix_data_i, last: frame_end || burst_end};
    assign w_valid_o   = pix_valid_i;
    assign pix_ready_o = w_ready_i;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame_cnt_q <= '0;
            burst_cnt_q <= '0;
        end
        else if (beat)
        begin
            frame_cnt_q <= frame_end ? '0 : frame_cnt_q + 1'b1;
            burst_cnt_q <= (frame_end || burst_end) ? '0 : burst_cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/frame_ring.sv
`timescale 1ns/1ps
`default_nettype none

module frame_ring import frame_buffer_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_done_i,        // last B of a written frame
    input  logic        rd_done_i,        // last R of a read frame
    input  logic        disp_suspend_i,
    output logic        wr_release_o,
    output logic        rd_release_o,
    output logic [31:0] wr_base_o,
    output logic [31:0] rd_base_o,
    output frame_id_t   rd_fid_o,
    output logic        rd_new_frame_o
);

    slot_vec_t   wr_ptr_q;
    slot_vec_t   rd_ptr_q;
    slot_vec_t   filled_q;
    slot_vec_t   wr_ptr_nxt;
    slot_vec_t   rd_ptr_nxt;
    logic        ring_full;
    logic        ring_empty;
    logic        wr_pend_q;     // written frame waiting for a free slot
    logic        wr_commit;
    logic        rd_advance;
    logic [31:0] wr_base_q;
    logic [31:0] rd_base_q;
    frame_id_t   rd_fid_q;
    logic        rd_new_frame_q;

    assign wr_ptr_nxt = {wr_ptr_q[FRAME_N-2:0], wr_ptr_q[FRAME_N-1]};
    assign rd_ptr_nxt = {rd_ptr_q[FRAME_N-2:0], rd_ptr_q[FRAME_N-1]};

    assign ring_full  = |(wr_ptr_nxt & filled_q);
    assign ring_empty = ~|(rd_ptr_nxt & filled_q);   // nothing newer to show

    assign wr_commit  = wr_pend_q && !ring_full;
    assign rd_advance = rd_done_i && !ring_empty && !disp_suspend_i;

    // reader always restarts, on a new slot or the same one
    assign rd_release_o = rd_done_i;
    assign wr_release_o = wr_commit;

    assign wr_base_o      = wr_base_q;
    assign rd_base_o      = rd_base_q;
    assign rd_fid_o       = rd_fid_q;
    assign rd_new_frame_o = rd_new_frame_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wr_pend_q <= 1'b0;
        else if (wr_pend_q)
            wr_pend_q <= ring_full;      // hold until committed
        else
            wr_pend_q <= wr_done_i;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr_q  <= slot_vec_t'(1);
            rd_ptr_q  <= {1'b1, {(FRAME_N-1){1'b0}}};
            filled_q  <= {1'b1, {(FRAME_N-1){1'b0}}};   // last slot counts as shown
            wr_base_q <= BUF_BASE_ADDR;
            rd_base_q <= LAST_SLOT_ADDR;
        end
        else
        begin
            // writer never sits on the reader's slot, so the two never collide
            filled_q <= (filled_q & ~(rd_advance ? rd_ptr_q : '0))
                        | (wr_commit ? wr_ptr_q : '0);
            if (wr_commit)
            begin
                wr_ptr_q  <= wr_ptr_nxt;
                wr_base_q <= wr_ptr_q[FRAME_N-1] ? BUF_BASE_ADDR : wr_base_q + FRAME_BYTES;
            end
            if (rd_advance)
            begin
                rd_ptr_q  <= rd_ptr_nxt;
                rd_base_q <= rd_ptr_q[FRAME_N-1] ? BUF_BASE_ADDR : rd_base_q + FRAME_BYTES;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_fid_q       <= '0;
            rd_new_frame_q <= 1'b0;
        end
        else
        begin
            rd_new_frame_q <= rd_advance;
            if (rd_advance)
                rd_fid_q <= rd_fid_q + 8'd1;   // repeated frames keep their id
        end
    end

endmodule

`default_nettype wire

// File: source/burst_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module burst_addr_gen import frame_buffer_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] frame_base_i,    // slot base from the ring
    output addr_req_t   req_o,
    output logic        req_valid_o,
    input  logic        req_ready_i,
    input  logic        burst_done_i,    // R last beat or B beat
    output logic        frame_done_o,
    input  logic        frame_release_i
);

    logic [31:0] remain_q;      // words still to request in this frame
    logic [31:0] ofs_q;         // byte offset within the frame
    logic        running_q;     // final burst out, waiting for release
    logic        last_burst;
    logic [31:0] burst_words;
    logic        tag_full;
    logic        tag_last;
    logic        accept;

    // shorter tail burst once the remainder fits
    assign last_burst  = (remain_q <= MAX_BURST);
    assign burst_words = last_burst ? remain_q : MAX_BURST;

    assign req_valid_o = !tag_full && !running_q;
    assign req_o       = '{addr: frame_base_i + ofs_q, len: 8'(burst_words - 32'd1)};
    assign accept      = req_valid_o && req_ready_i;

    assign frame_done_o = burst_done_i && tag_last;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            remain_q <= FRAME_DWORDS;
            ofs_q    <= '0;
        end
        else if (accept)
        begin
            if (last_burst)
            begin
                remain_q <= FRAME_DWORDS;   // rewind for the next frame
                ofs_q    <= '0;
            end
            else
            begin
                remain_q <= remain_q - MAX_BURST;
                ofs_q    <= ofs_q + BURST_BYTES;
            end
        end
    end

    // no new addresses until the ring has moved the base
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            running_q <= 1'b0;
        else if (accept && last_burst)
            running_q <= 1'b1;
        else if (frame_release_i)
            running_q <= 1'b0;
    end

    // one flag per burst in flight, popped in completion order
    burst_tag_fifo u_tag_fifo
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .push_i (accept),
        .tag_i  (last_burst),
        .full_o (tag_full),
        .pop_i  (burst_done_i),
        .tag_o  (tag_last)
    );

endmodule

`default_nettype wire

// File: source/burst_tag_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module burst_tag_fifo import frame_buffer_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic push_i,
    input  logic tag_i,     // 1 = last burst of frame
    output logic full_o,
    input  logic pop_i,
    output logic tag_o
);

    logic [ADDR_OUTSTANDING-1:0] tag_q;   // entry 0 is the oldest
    logic [ADDR_OUTSTANDING-1:0] tag_d;
    logic [TAG_CNT_W-1:0]        cnt_q;
    logic [TAG_CNT_W-1:0]        wr_idx;

    assign full_o = (cnt_q == TAG_CNT_W'(ADDR_OUTSTANDING));
    assign tag_o  = tag_q[0];
    assign wr_idx = cnt_q - TAG_CNT_W'(pop_i);   // slot after the shift

    always_comb
    begin
        tag_d = pop_i ? (tag_q >> 1) : tag_q;
        for (int i = 0; i < ADDR_OUTSTANDING; i++)
        begin
            if (push_i && (TAG_CNT_W'(i) == wr_idx))
                tag_d[i] = tag_i;
        end
    end

    always_ff @(posedge clk)
        tag_q <= tag_d;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cnt_q <= '0;
        else if (push_i && !pop_i)
            cnt_q <= cnt_q + 1'b1;
        else if (pop_i && !push_i)
            cnt_q <= cnt_q - 1'b1;
    end

endmodule

`default_nettype wire

// File: source/frame_buffer_pkg.sv
`default_nettype none

package frame_buffer_pkg;

    // frame store geometry
    localparam int unsigned FRAME_N      = 4;
    localparam int unsigned FRAME_DWORDS = 40;                  // 32-bit words per frame
    localparam logic [31:0] FRAME_BYTES  = 32'(4 * FRAME_DWORDS);

    localparam logic [31:0] BUF_BASE_ADDR  = 32'h0001_0000;     // slot 0
    localparam logic [31:0] LAST_SLOT_ADDR = BUF_BASE_ADDR + 32'(FRAME_N - 1) * FRAME_BYTES;

    // burst shape
    localparam int unsigned MAX_BURST        = 16;
    localparam logic [31:0] BURST_BYTES      = 32'(4 * MAX_BURST);
    localparam int unsigned ADDR_OUTSTANDING = 2;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_4B    = 3'b010;

    // counter widths
    localparam int unsigned TAG_CNT_W   = $clog2(ADDR_OUTSTANDING + 1);
    localparam int unsigned WORD_CNT_W  = $clog2(FRAME_DWORDS);
    localparam int unsigned BURST_CNT_W = $clog2(MAX_BURST);

    typedef logic [FRAME_N-1:0] slot_vec_t;   // one-hot slot
    typedef logic [7:0]         frame_id_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;     // beats minus one
    } addr_req_t;

    typedef struct packed {
        logic [31:0] data;
        frame_id_t   fid;
        logic        last;    // final word of frame
    } pix_beat_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } wr_beat_t;

endpackage

`default_nettype wire
